// File: src/painter_pkg.sv
`default_nettype none

package painter_pkg;

	// board and screen geometry in cells and pixels
	localparam int BOARD_W = 4;
	localparam int BOARD_H = 4;
	localparam int CELL_PX = 8;
	localparam int SCR_W = 32;
	localparam int SCR_H = 40;
	localparam int BOARD_Y0 = 8;

	// victory stone sits in the cell-sized area above the board
	localparam int VICTORY_X0 = 0;
	localparam int VICTORY_Y0 = 0;

	// squared radius for the doubled-offset circle test
	localparam int CIRCLE_R2 = 64;

	localparam int COLOR_W = 3;

	typedef logic [COLOR_W-1:0] color_t;
	typedef logic [$clog2(SCR_W)-1:0] pix_x_t;
	typedef logic [$clog2(SCR_H)-1:0] pix_y_t;
	// address is y*SCR_W + x
	typedef logic [$clog2(SCR_W*SCR_H)-1:0] fb_addr_t;
	// row-major with the column in the low bits
	typedef logic [$clog2(BOARD_W*BOARD_H)-1:0] cell_idx_t;
	typedef logic [$clog2(BOARD_W)-1:0] cell_coord_t;
	// two bits per cell with cell k at bits 2k and 2k+1
	typedef logic [2*BOARD_W*BOARD_H-1:0] board_t;

	localparam color_t COLOR_BLACK_STONE = 3'b001;
	localparam color_t COLOR_WHITE_STONE = 3'b110;
	localparam color_t COLOR_POINTER = 3'b100;

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_BLACK = 2'd1,
		CELL_WHITE = 2'd2
	} cell_state_e;

	typedef enum logic [1:0] {
		WIN_NONE = 2'd0,
		WIN_BLACK = 2'd1,
		WIN_WHITE = 2'd2
	} winner_e;

	// shape opcode for the rasterizer
	typedef enum logic {
		SHAPE_SQUARE = 1'b0,
		SHAPE_CIRCLE = 1'b1
	} shape_e;

endpackage

`default_nettype wire

// File: src/cell_scanner.sv
`default_nettype none
`timescale 1ns/1ps

module cell_scanner (
	input logic Clck,
	input logic rst_n,
	input logic start,
	input painter_pkg::board_t board,
	input painter_pkg::cell_coord_t pointer_x,
	input painter_pkg::cell_coord_t pointer_y,
	input painter_pkg::winner_e winner,
	output logic busy,
	output logic cell_valid,
	input logic cell_ready,
	output painter_pkg::cell_idx_t cell_idx,
	output painter_pkg::cell_state_e cell_state,
	output logic scan_last,
	output painter_pkg::cell_coord_t snap_pointer_x,
	output painter_pkg::cell_coord_t snap_pointer_y,
	output painter_pkg::winner_e snap_winner,
	input logic frame_end
);

	localparam int CELLS = painter_pkg::BOARD_W * painter_pkg::BOARD_H;

	painter_pkg::board_t snap_board;
	painter_pkg::cell_idx_t scan_idx;
	logic scanning;
	logic [CELLS-1:0] occ_mask;
	logic accept;
	logic step;
	logic occ_none;
	logic hit;
	logic rest_empty;

	// one bit per cell that holds a stone
	always_comb
	begin
		for (int k = 0; k < CELLS; k++)
		begin
			occ_mask[k] = (snap_board[2*k +: 2] == painter_pkg::CELL_BLACK) ||
				(snap_board[2*k +: 2] == painter_pkg::CELL_WHITE);
		end
	end

	assign accept = start && !busy;
	assign step = scanning && !cell_valid;
	assign occ_none = (occ_mask == '0);
	assign hit = occ_mask[scan_idx];
	// nothing occupied above the current cell
	assign rest_empty = ((occ_mask >> scan_idx) == CELLS'(1));

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			scanning <= 1'b0;
			scan_idx <= '0;
			cell_valid <= 1'b0;
		end
		else
		begin
			if (accept)
			begin
				busy <= 1'b1;
				scanning <= 1'b1;
				scan_idx <= '0;
			end
			else if (frame_end)
			begin
				busy <= 1'b0;
			end

			if (cell_valid && cell_ready)
			begin
				cell_valid <= 1'b0;
			end
			else if (step)
			begin
				// empty board sends a single closing token
				if (occ_none)
				begin
					cell_valid <= 1'b1;
					scanning <= 1'b0;
				end
				else if (hit)
				begin
					cell_valid <= 1'b1;
					scanning <= !rest_empty;
					scan_idx <= scan_idx + 1'b1;
				end
				else
				begin
					scan_idx <= scan_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clck)
	begin
		if (accept)
		begin
			snap_board <= board;
			snap_pointer_x <= pointer_x;
			snap_pointer_y <= pointer_y;
			snap_winner <= winner;
		end
		if (step && (occ_none || hit))
		begin
			cell_idx <= scan_idx;
			cell_state <= occ_none ? painter_pkg::CELL_EMPTY :
				painter_pkg::cell_state_e'(snap_board[{scan_idx, 1'b0} +: 2]);
			scan_last <= occ_none || rest_empty;
		end
	end

endmodule

`default_nettype wire

// File: src/scene_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module scene_sequencer (
	input logic Clck,
	input logic rst_n,
	input logic cell_valid,
	output logic cell_ready,
	input painter_pkg::cell_idx_t cell_idx,
	input painter_pkg::cell_state_e cell_state,
	input logic scan_last,
	input painter_pkg::cell_coord_t snap_pointer_x,
	input painter_pkg::cell_coord_t snap_pointer_y,
	input painter_pkg::winner_e snap_winner,
	output logic shape_valid,
	input logic shape_ready,
	output painter_pkg::pix_x_t shape_x,
	output painter_pkg::pix_y_t shape_y,
	output painter_pkg::shape_e shape_kind,
	output painter_pkg::color_t shape_color,
	input logic raster_idle,
	input logic bus_idle,
	output logic frame_end,
	output logic done
);

	// stones also serves as the idle phase between frames
	typedef enum logic [1:0] {
		ST_STONES,
		ST_POINTER,
		ST_VICTORY,
		ST_DRAIN
	} seq_state_e;

	seq_state_e state;
	logic done_q;
	logic shape_free;
	logic take_cell;
	logic stone_job;
	logic issue;
	logic drained;
	painter_pkg::pix_x_t nxt_x;
	painter_pkg::pix_y_t nxt_y;
	painter_pkg::shape_e nxt_kind;
	painter_pkg::color_t nxt_color;

	function automatic painter_pkg::pix_x_t origin_x(input painter_pkg::cell_coord_t col);
		return painter_pkg::pix_x_t'(col * painter_pkg::CELL_PX);
	endfunction

	function automatic painter_pkg::pix_y_t origin_y(input painter_pkg::cell_coord_t row);
		return painter_pkg::pix_y_t'(painter_pkg::BOARD_Y0 + row * painter_pkg::CELL_PX);
	endfunction

	// output slot is empty or being emptied this cycle
	assign shape_free = !shape_valid || shape_ready;
	assign cell_ready = (state == ST_STONES) && shape_free;
	assign take_cell = cell_valid && cell_ready;
	// the closing token of an empty board carries no stone
	assign stone_job = take_cell && (cell_state != painter_pkg::CELL_EMPTY);
	assign issue = stone_job ||
		(((state == ST_POINTER) || (state == ST_VICTORY)) && shape_free);
	assign drained = !shape_valid && raster_idle && bus_idle;

	assign done = done_q;
	assign frame_end = done_q;

	always_comb
	begin
		nxt_kind = painter_pkg::SHAPE_CIRCLE;
		nxt_x = origin_x(cell_idx[1:0]);
		nxt_y = origin_y(cell_idx[3:2]);
		if (cell_state == painter_pkg::CELL_WHITE)
			nxt_color = painter_pkg::COLOR_WHITE_STONE;
		else
			nxt_color = painter_pkg::COLOR_BLACK_STONE;

		case (state)
			ST_POINTER:
			begin
				nxt_kind = painter_pkg::SHAPE_SQUARE;
				nxt_x = origin_x(snap_pointer_x);
				nxt_y = origin_y(snap_pointer_y);
				nxt_color = painter_pkg::COLOR_POINTER;
			end
			ST_VICTORY:
			begin
				nxt_x = painter_pkg::pix_x_t'(painter_pkg::VICTORY_X0);
				nxt_y = painter_pkg::pix_y_t'(painter_pkg::VICTORY_Y0);
				if (snap_winner == painter_pkg::WIN_WHITE)
					nxt_color = painter_pkg::COLOR_WHITE_STONE;
				else
					nxt_color = painter_pkg::COLOR_BLACK_STONE;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_STONES;
			shape_valid <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			if (issue)
				shape_valid <= 1'b1;
			else if (shape_ready)
				shape_valid <= 1'b0;

			done_q <= (state == ST_DRAIN) && drained;

			case (state)
				ST_STONES:
					if (take_cell && scan_last)
						state <= ST_POINTER;
				ST_POINTER:
					if (shape_free)
						state <= (snap_winner != painter_pkg::WIN_NONE) ? ST_VICTORY : ST_DRAIN;
				ST_VICTORY:
					if (shape_free)
						state <= ST_DRAIN;
				ST_DRAIN:
					// last pixels must leave the rasterizer and the bus first
					if (drained)
						state <= ST_STONES;
				default:
					state <= ST_STONES;
			endcase
		end
	end

	always_ff @(posedge Clck)
	begin
		if (issue)
		begin
			shape_x <= nxt_x;
			shape_y <= nxt_y;
			shape_kind <= nxt_kind;
			shape_color <= nxt_color;
		end
	end

endmodule

`default_nettype wire

// File: src/shape_rasterizer.sv
`default_nettype none
`timescale 1ns/1ps

module shape_rasterizer (
	input logic Clck,
	input logic rst_n,
	input logic shape_valid,
	output logic shape_ready,
	input painter_pkg::pix_x_t shape_x,
	input painter_pkg::pix_y_t shape_y,
	input painter_pkg::shape_e shape_kind,
	input painter_pkg::color_t shape_color,
	output logic raster_idle,
	output logic pix_valid,
	input logic pix_ready,
	output painter_pkg::fb_addr_t pix_adr,
	output painter_pkg::color_t pix_color
);

	localparam logic [2:0] LAST_OFF = 3'(painter_pkg::CELL_PX - 1);

	logic running;
	// local offset inside the 8 by 8 cell
	logic [2:0] lx;
	logic [2:0] ly;
	painter_pkg::pix_x_t ox;
	painter_pkg::pix_y_t oy;
	painter_pkg::shape_e kind;
	painter_pkg::color_t color;
	logic out_free;
	logic last_px;
	logic covered;
	logic [6:0] ax;
	logic [6:0] ay;
	logic [6:0] d2;
	painter_pkg::pix_x_t px;
	painter_pkg::pix_y_t py;

	assign shape_ready = !running;
	assign raster_idle = !running && !pix_valid;
	assign out_free = !pix_valid || pix_ready;
	assign last_px = (lx == LAST_OFF) && (ly == LAST_OFF);

	always_comb
	begin
		// |2*l - 7| is the distance from the cell centre in half pixels
		if (lx[2])
			ax = 7'({lx, 1'b0}) - 7'd7;
		else
			ax = 7'd7 - 7'({lx, 1'b0});
		if (ly[2])
			ay = 7'({ly, 1'b0}) - 7'd7;
		else
			ay = 7'd7 - 7'({ly, 1'b0});
		d2 = ax * ax + ay * ay;
		covered = (kind == painter_pkg::SHAPE_SQUARE) ||
			(d2 <= 7'(painter_pkg::CIRCLE_R2));
		px = ox + {2'b00, lx};
		py = oy + {3'b000, ly};
	end

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			lx <= '0;
			ly <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			if (shape_valid && shape_ready)
			begin
				running <= 1'b1;
				lx <= '0;
				ly <= '0;
			end
			else if (running && out_free)
			begin
				// row by row, left to right
				lx <= lx + 1'b1;
				if (lx == LAST_OFF)
					ly <= ly + 1'b1;
				if (last_px)
					running <= 1'b0;
			end

			// an uncovered pixel still uses its cycle
			if (running && out_free)
				pix_valid <= covered;
			else if (pix_ready)
				pix_valid <= 1'b0;
		end
	end

	always_ff @(posedge Clck)
	begin
		if (shape_valid && shape_ready)
		begin
			ox <= shape_x;
			oy <= shape_y;
			kind <= shape_kind;
			color <= shape_color;
		end
		if (running && out_free && covered)
		begin
			pix_adr <= painter_pkg::fb_addr_t'(py * painter_pkg::SCR_W + px);
			pix_color <= color;
		end
	end

endmodule

`default_nettype wire

// File: src/pixel_bus_master.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_bus_master (
	input logic Clck,
	input logic rst_n,
	input logic pix_valid,
	output logic pix_ready,
	input painter_pkg::fb_addr_t pix_adr,
	input painter_pkg::color_t pix_color,
	output logic bus_idle,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output painter_pkg::fb_addr_t wb_adr,
	output painter_pkg::color_t wb_dat,
	input logic wb_ack
);

	// a single write cycle is open on the bus
	logic active;
	logic take;

	assign take = pix_valid && pix_ready;

	// accepts a new pixel only once the strobes are down
	assign pix_ready = !active;
	assign bus_idle = !active;

	// write-only master, so cyc, stb and we move as one
	assign wb_cyc = active;
	assign wb_stb = active;
	assign wb_we = active;

	always_ff @(posedge Clck or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
		end
		else if (take)
		begin
			active <= 1'b1;
		end
		else if (active && wb_ack)
		begin
			active <= 1'b0;
		end
	end

	// held while the write is open
	always_ff @(posedge Clck)
	begin
		if (take)
		begin
			wb_adr <= pix_adr;
			wb_dat <= pix_color;
		end
	end

endmodule

`default_nettype wire

// File: src/board_painter.sv
`default_nettype none
`timescale 1ns/1ps

module board_painter (
	input logic Clck,
	input logic rst_n,
	input logic start,
	input painter_pkg::board_t board,
	input painter_pkg::cell_coord_t pointer_x,
	input painter_pkg::cell_coord_t pointer_y,
	input painter_pkg::winner_e winner,
	output logic busy,
	output logic done,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output painter_pkg::fb_addr_t wb_adr,
	output painter_pkg::color_t wb_dat,
	input logic wb_ack
);

	// scanner to sequencer
	logic cell_valid;
	logic cell_ready;
	painter_pkg::cell_idx_t cell_idx;
	painter_pkg::cell_state_e cell_state;
	logic scan_last;
	painter_pkg::cell_coord_t snap_pointer_x;
	painter_pkg::cell_coord_t snap_pointer_y;
	painter_pkg::winner_e snap_winner;
	logic frame_end;

	// sequencer to rasterizer
	logic shape_valid;
	logic shape_ready;
	painter_pkg::pix_x_t shape_x;
	painter_pkg::pix_y_t shape_y;
	painter_pkg::shape_e shape_kind;
	painter_pkg::color_t shape_color;
	logic raster_idle;

	// rasterizer to bus master
	logic pix_valid;
	logic pix_ready;
	painter_pkg::fb_addr_t pix_adr;
	painter_pkg::color_t pix_color;
	logic bus_idle;

	cell_scanner u_scanner (
		.Clck(Clck),
		.rst_n(rst_n),
		.start(start),
		.board(board),
		.pointer_x(pointer_x),
		.pointer_y(pointer_y),
		.winner(winner),
		.busy(busy),
		.cell_valid(cell_valid),
		.cell_ready(cell_ready),
		.cell_idx(cell_idx),
		.cell_state(cell_state),
		.scan_last(scan_last),
		.snap_pointer_x(snap_pointer_x),
		.snap_pointer_y(snap_pointer_y),
		.snap_winner(snap_winner),
		.frame_end(frame_end)
	);

	scene_sequencer u_sequencer (
		.Clck(Clck),
		.rst_n(rst_n),
		.cell_valid(cell_valid),
		.cell_ready(cell_ready),
		.cell_idx(cell_idx),
		.cell_state(cell_state),
		.scan_last(scan_last),
		.snap_pointer_x(snap_pointer_x),
		.snap_pointer_y(snap_pointer_y),
		.snap_winner(snap_winner),
		.shape_valid(shape_valid),
		.shape_ready(shape_ready),
		.shape_x(shape_x),
		.shape_y(shape_y),
		.shape_kind(shape_kind),
		.shape_color(shape_color),
		.raster_idle(raster_idle),
		.bus_idle(bus_idle),
		.frame_end(frame_end),
		.done(done)
	);

	shape_rasterizer u_rasterizer (
		.Clck(Clck),
		.rst_n(rst_n),
		.shape_valid(shape_valid),
		.shape_ready(shape_ready),
		.shape_x(shape_x),
		.shape_y(shape_y),
		.shape_kind(shape_kind),
		.shape_color(shape_color),
		.raster_idle(raster_idle),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.pix_adr(pix_adr),
		.pix_color(pix_color)
	);

	pixel_bus_master u_master (
		.Clck(Clck),
		.rst_n(rst_n),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.pix_adr(pix_adr),
		.pix_color(pix_color),
		.bus_idle(bus_idle),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

// File: testbench/board_painter_properties.sv
`default_nettype none
`timescale 1ns/1ps

module board_painter_properties (
	input logic Clck,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input painter_pkg::fb_addr_t wb_adr,
	input painter_pkg::color_t wb_dat,
	input painter_pkg::cell_coord_t snap_pointer_x,
	input painter_pkg::cell_coord_t snap_pointer_y,
	input painter_pkg::winner_e snap_winner
);

	int fail_count = 0;

	stb_in_cycle: assert property (@(posedge Clck) disable iff (!rst_n) wb_stb |-> wb_cyc)
	else
	begin
		fail_count++;
		$error("wb_stb high without wb_cyc");
	end

	// address and data hold until the slave acks
	write_held: assert property (@(posedge Clck) disable iff (!rst_n)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat)))
	else
	begin
		fail_count++;
		$error("write dropped or changed before ack");
	end

	strobe_drop: assert property (@(posedge Clck) disable iff (!rst_n)
		(wb_stb && wb_ack) |=> !wb_cyc)
	else
	begin
		fail_count++;
		$error("bus cycle still open after ack");
	end

	done_in_frame: assert property (@(posedge Clck) disable iff (!rst_n) done |-> busy)
	else
	begin
		fail_count++;
		$error("done pulsed outside a frame");
	end

	// a start during a frame must leave the snapshot alone
	start_ignored: assert property (@(posedge Clck) disable iff (!rst_n)
		(start && busy) |=>
		($stable(snap_pointer_x) && $stable(snap_pointer_y) && $stable(snap_winner)))
	else
	begin
		fail_count++;
		$error("start accepted while busy");
	end

endmodule

bind board_painter board_painter_properties props (
	.Clck(Clck),
	.rst_n(rst_n),
	.start(start),
	.busy(busy),
	.done(done),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.wb_adr(wb_adr),
	.wb_dat(wb_dat),
	.snap_pointer_x(snap_pointer_x),
	.snap_pointer_y(snap_pointer_y),
	.snap_winner(snap_winner)
);

`default_nettype wire

// File: testbench/board_painter_tb.sv
`default_nettype none
`timescale 1ns/1ps

module board_painter_tb;

	localparam int DONE_TIMEOUT = 20000;

	logic Clck;
	logic rst_n;
	logic start;
	painter_pkg::board_t board;
	painter_pkg::cell_coord_t pointer_x;
	painter_pkg::cell_coord_t pointer_y;
	painter_pkg::winner_e winner;
	logic busy;
	logic done;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	painter_pkg::fb_addr_t wb_adr;
	painter_pkg::color_t wb_dat;
	logic wb_ack;

	// slave model state
	logic slow_ack;
	logic in_xfer;
	int wait_left;
	painter_pkg::fb_addr_t got_adr[$];
	painter_pkg::color_t got_col[$];
	painter_pkg::fb_addr_t exp_adr[$];
	painter_pkg::color_t exp_col[$];

	board_painter uut (
		.Clck(Clck),
		.rst_n(rst_n),
		.start(start),
		.board(board),
		.pointer_x(pointer_x),
		.pointer_y(pointer_y),
		.winner(winner),
		.busy(busy),
		.done(done),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

	always #4 Clck = ~Clck;

	// frame buffer slave that acks after 0 to 3 cycles and logs each write
	always @(posedge Clck)
	begin
		#1;
		// stb and we follow cyc in every cycle
		if (wb_cyc)
		begin
			check_flag("wb_stb", wb_stb, 1'b1);
			check_flag("wb_we", wb_we, 1'b1);
		end
		else
		begin
			check_flag("wb_stb", wb_stb, 1'b0);
			check_flag("wb_we", wb_we, 1'b0);
		end
		if (wb_ack)
			wb_ack = 1'b0;
		else if (wb_cyc && wb_stb && wb_we)
		begin
			if (!in_xfer)
			begin
				in_xfer = 1'b1;
				wait_left = slow_ack ? 3 : int'($urandom_range(3, 0));
			end
			if (wait_left == 0)
			begin
				got_adr.push_back(wb_adr);
				got_col.push_back(wb_dat);
				wb_ack = 1'b1;
				in_xfer = 1'b0;
			end
			else
				wait_left--;
		end
	end

	always @(posedge Clck)
	begin
		#1;
		if (uut.props.fail_count != 0)
			fail_now("protocol assertion failed in the bound checker");
	end

	task automatic next_cycle;
		@(posedge Clck);
		#1;
	endtask

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_addr(input string name, input painter_pkg::fb_addr_t got,
		input painter_pkg::fb_addr_t exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_color(input string name, input painter_pkg::color_t got,
		input painter_pkg::color_t exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// expected writes of one cell-sized shape row by row from the left
	task automatic add_shape(input int x0, input int y0, input bit circle,
		input painter_pkg::color_t c);
		int dx;
		int dy;
		for (int ly = 0; ly < painter_pkg::CELL_PX; ly++)
		begin
			for (int lx = 0; lx < painter_pkg::CELL_PX; lx++)
			begin
				dx = 2 * lx - 7;
				dy = 2 * ly - 7;
				if (!circle || (dx * dx + dy * dy <= painter_pkg::CIRCLE_R2))
				begin
					exp_adr.push_back(painter_pkg::fb_addr_t'((y0 + ly) * painter_pkg::SCR_W
						+ x0 + lx));
					exp_col.push_back(c);
				end
			end
		end
	endtask

	task automatic build_expected(input painter_pkg::board_t b, input int px, input int py,
		input painter_pkg::winner_e w);
		int st;
		int cx;
		int cy;
		exp_adr.delete();
		exp_col.delete();
		for (int k = 0; k < painter_pkg::BOARD_W * painter_pkg::BOARD_H; k++)
		begin
			st = b[2*k +: 2];
			cx = (k % painter_pkg::BOARD_W) * painter_pkg::CELL_PX;
			cy = painter_pkg::BOARD_Y0 + (k / painter_pkg::BOARD_W) * painter_pkg::CELL_PX;
			if (st == painter_pkg::CELL_BLACK)
				add_shape(cx, cy, 1'b1, painter_pkg::COLOR_BLACK_STONE);
			else if (st == painter_pkg::CELL_WHITE)
				add_shape(cx, cy, 1'b1, painter_pkg::COLOR_WHITE_STONE);
		end
		add_shape(px * painter_pkg::CELL_PX,
			painter_pkg::BOARD_Y0 + py * painter_pkg::CELL_PX, 1'b0, painter_pkg::COLOR_POINTER);
		// victory stone in the corner area above the board
		if (w == painter_pkg::WIN_BLACK)
			add_shape(0, 0, 1'b1, painter_pkg::COLOR_BLACK_STONE);
		else if (w == painter_pkg::WIN_WHITE)
			add_shape(0, 0, 1'b1, painter_pkg::COLOR_WHITE_STONE);
	endtask

	task automatic start_frame(input painter_pkg::board_t b, input painter_pkg::cell_coord_t px,
		input painter_pkg::cell_coord_t py, input painter_pkg::winner_e w);
		check_flag("busy", busy, 1'b0);
		got_adr.delete();
		got_col.delete();
		build_expected(b, px, py, w);
		board = b;
		pointer_x = px;
		pointer_y = py;
		winner = w;
		start = 1'b1;
		next_cycle;
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
	endtask

	task automatic wait_done;
		int cycles;
		cycles = 0;
		while (done !== 1'b1)
		begin
			if (cycles == DONE_TIMEOUT)
				fail_now("timeout while waiting for done");
			else
			begin
				next_cycle;
				cycles++;
			end
		end
		check_flag("busy", busy, 1'b1);
		next_cycle;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
	endtask

	task automatic compare_writes;
		check_count("write count", got_adr.size(), exp_adr.size());
		foreach (exp_adr[i])
		begin
			check_addr($sformatf("wb_adr[%0d]", i), got_adr[i], exp_adr[i]);
			check_color($sformatf("wb_dat[%0d]", i), got_col[i], exp_col[i]);
		end
	endtask

	task automatic run_frame(input painter_pkg::board_t b, input painter_pkg::cell_coord_t px,
		input painter_pkg::cell_coord_t py, input painter_pkg::winner_e w);
		start_frame(b, px, py, w);
		wait_done;
		compare_writes;
	endtask

	function automatic painter_pkg::board_t random_board;
		painter_pkg::board_t b;
		for (int k = 0; k < painter_pkg::BOARD_W * painter_pkg::BOARD_H; k++)
			b[2*k +: 2] = 2'($urandom_range(2, 0));
		return b;
	endfunction

	task automatic test_empty_board;
		run_frame('0, 2'd2, 2'd3, painter_pkg::WIN_NONE);
		check_count("pointer writes", got_adr.size(), 64);
		foreach (got_col[i])
			check_color($sformatf("wb_dat[%0d]", i), got_col[i], painter_pkg::COLOR_POINTER);
	endtask

	task automatic test_two_stones;
		painter_pkg::board_t b;
		painter_pkg::fb_addr_t centre;
		painter_pkg::color_t last_col;
		b = '0;
		b[2*1 +: 2] = painter_pkg::CELL_BLACK;
		b[2*6 +: 2] = painter_pkg::CELL_WHITE;
		// pointer sits on the white stone at column 2, row 1
		run_frame(b, 2'd2, 2'd1, painter_pkg::WIN_NONE);
		centre = painter_pkg::fb_addr_t'(19 * painter_pkg::SCR_W + 19);
		last_col = '0;
		foreach (got_adr[i])
			if (got_adr[i] == centre)
				last_col = got_col[i];
		check_color("pointer over stone", last_col, painter_pkg::COLOR_POINTER);
	endtask

	task automatic test_random_boards;
		for (int w = 0; w < 3; w++)
			run_frame(random_board(), 2'($urandom_range(3, 0)), 2'($urandom_range(3, 0)),
				painter_pkg::winner_e'(w));
	endtask

	task automatic test_snapshot;
		start_frame(random_board(), 2'd1, 2'd2, painter_pkg::WIN_BLACK);
		repeat (5) next_cycle;
		// new inputs and a second start in the middle of the frame
		board = random_board();
		pointer_x = 2'd3;
		pointer_y = 2'd0;
		winner = painter_pkg::WIN_WHITE;
		start = 1'b1;
		next_cycle;
		start = 1'b0;
		wait_done;
		compare_writes;
		run_frame(random_board(), 2'd3, 2'd0, painter_pkg::WIN_WHITE);
	endtask

	task automatic test_back_pressure;
		slow_ack = 1'b1;
		run_frame(random_board(), 2'd0, 2'd3, painter_pkg::WIN_WHITE);
		slow_ack = 1'b0;
	endtask

	initial
	begin
		Clck = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		board = '0;
		pointer_x = '0;
		pointer_y = '0;
		winner = painter_pkg::WIN_NONE;
		wb_ack = 1'b0;
		slow_ack = 1'b0;
		in_xfer = 1'b0;
		wait_left = 0;
		void'($urandom(4274));
		repeat (2) @(posedge Clck);
		#1;
		rst_n = 1'b1;
		next_cycle;
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("wb_cyc", wb_cyc, 1'b0);

		test_empty_board;
		test_two_stones;
		test_random_boards;
		test_snapshot;
		test_back_pressure;

		if (uut.props.fail_count == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			fail_now("protocol assertion failed in the bound checker");
		end
	end

endmodule

`default_nettype wire

// File: project.f
src/painter_pkg.sv
src/cell_scanner.sv
src/scene_sequencer.sv
src/shape_rasterizer.sv
src/pixel_bus_master.sv
src/board_painter.sv
testbench/board_painter_properties.sv
testbench/board_painter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= board_painter_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
